// ==== logic/osPkg.sv ====
package osPkg;

    typedef logic [7:0]   symbol_t;
    typedef logic [127:0] orderedSet_t;   // Symbol 0 in bits 7:0
    typedef logic [3:0]   substate_t;

    // Symbol codes
    localparam symbol_t symCom     = 8'hBC;  // K28.5 comma
    localparam symbol_t symPad     = 8'hF7;  // K23.7
    localparam symbol_t symTs1Id   = 8'h2A;
    localparam symbol_t symTs2Id   = 8'h25;
    localparam symbol_t symGen3Ts1 = 8'h1E;  // 128b/130b TS1 start
    localparam symbol_t symGen3Ts2 = 8'h2D;  // 128b/130b TS2 start
    localparam symbol_t symIdle    = 8'h00;

    // Substate codes from the LTSSM
    localparam substate_t detectQuiet           = 4'd0;
    localparam substate_t detectActive          = 4'd1;
    localparam substate_t pollingActive         = 4'd2;
    localparam substate_t pollingConfiguration  = 4'd3;
    localparam substate_t configLinkWidthStart  = 4'd4;
    localparam substate_t configLinkWidthAccept = 4'd5;
    localparam substate_t configLanenumWait     = 4'd6;
    localparam substate_t configLanenumAccept   = 4'd7;
    localparam substate_t configComplete        = 4'd8;
    localparam substate_t configIdle            = 4'd9;

    // Symbol positions within a TS
    localparam int linkSym = 1;
    localparam int laneSym = 2;
    localparam int rateSym = 4;
    localparam int idSym   = 10;

    // Bit positions within the set
    localparam int upconfigBit   = 42;  // Symbol 5 bit 2
    localparam int complianceBit = 43;  // Symbol 5 bit 3

    typedef enum logic [1:0]
    {
        trackIdle,
        trackHunt,
        trackRun
    } trackState_t;

endpackage

// ==== logic/osFieldsIf.sv ====
`timescale 1ns/10ps

interface osFieldsIf;

    logic ts1Start;
    logic ts2Start;
    logic isTs1;
    logic isTs2;
    logic linkIsPad;
    logic laneIsPad;
    logic linkMatch;
    logic laneMatch;
    logic isIdleData;
    logic tsAcceptable;

    modport decoder (
        output ts1Start, ts2Start, isTs1, isTs2, linkIsPad, laneIsPad,
               linkMatch, laneMatch, isIdleData, tsAcceptable
    );

    modport rules (
        input ts1Start, ts2Start, isTs1, isTs2, linkIsPad, laneIsPad,
              linkMatch, laneMatch, isIdleData, tsAcceptable
    );

endinterface

// ==== logic/osDecoder.sv ====
`timescale 1ns/10ps

module osDecoder (
    input  osPkg::orderedSet_t orderedSet,
    input  osPkg::symbol_t     linkNumber,
    input  osPkg::symbol_t     laneNumber,
    osFieldsIf.decoder         fields
);
    import osPkg::*;

    symbol_t startSymbol;
    symbol_t linkSymbol;
    symbol_t laneSymbol;
    symbol_t idSymbol;
    logic    complianceReq;
    logic    upconfigCap;

    assign startSymbol = orderedSet[7:0];
    assign linkSymbol  = orderedSet[linkSym*8 +: 8];
    assign laneSymbol  = orderedSet[laneSym*8 +: 8];
    assign idSymbol    = orderedSet[idSym*8 +: 8];

    assign complianceReq = orderedSet[complianceBit];
    assign upconfigCap   = orderedSet[upconfigBit];

    // Either encoding may open a TS
    assign fields.ts1Start = (startSymbol == symCom) || (startSymbol == symGen3Ts1);
    assign fields.ts2Start = (startSymbol == symCom) || (startSymbol == symGen3Ts2);

    assign fields.isTs1 = (idSymbol == symTs1Id);
    assign fields.isTs2 = (idSymbol == symTs2Id);

    assign fields.linkIsPad = (linkSymbol == symPad);
    assign fields.laneIsPad = (laneSymbol == symPad);
    assign fields.linkMatch = (linkSymbol == linkNumber);
    assign fields.laneMatch = (laneSymbol == laneNumber);

    assign fields.isIdleData = (startSymbol == symIdle);

    // Compliance request only counts when the partner cannot upconfigure
    assign fields.tsAcceptable = !((idSymbol == symTs1Id) && complianceReq && !upconfigCap);

endmodule

// ==== logic/osRuleSelect.sv ====
`timescale 1ns/10ps

module osRuleSelect #(
    parameter bit upstreamPort = 1'b0
) (
    input  osPkg::substate_t substate,
    osFieldsIf.rules         fields,
    output logic             ruleExists,
    output logic             setMatches,
    output logic             needsStable
);
    import osPkg::*;

    logic ts1Ok;
    logic ts2Ok;
    logic bothPad;
    logic bothMatch;

    assign ts1Ok     = fields.ts1Start && fields.isTs1;
    assign ts2Ok     = fields.ts2Start && fields.isTs2;
    assign bothPad   = fields.linkIsPad && fields.laneIsPad;
    assign bothMatch = fields.linkMatch && fields.laneMatch;

    always_comb
    begin
        ruleExists  = 1'b1;
        setMatches  = 1'b0;
        needsStable = 1'b0;
        case (substate)
            pollingActive:
                setMatches = (ts1Ok && bothPad && fields.tsAcceptable) || (ts2Ok && bothPad);
            pollingConfiguration:
                setMatches = ts2Ok && bothPad;
            configLinkWidthStart:
                if (upstreamPort)
                    setMatches = ts1Ok && !fields.linkIsPad && fields.laneIsPad;
                else
                    setMatches = ts1Ok && fields.linkMatch && fields.laneIsPad;
            configLinkWidthAccept:
            begin
                // Upstream only
                ruleExists = upstreamPort;
                setMatches = upstreamPort && ts1Ok && fields.linkMatch && !fields.laneIsPad;
            end
            configLanenumWait,
            configLanenumAccept:
                if (upstreamPort)
                    setMatches = ts2Ok && bothMatch;
                else
                    setMatches = ts1Ok && bothMatch;
            configComplete:
            begin
                needsStable = 1'b1;  // Rate and upconfigure must hold
                setMatches  = ts2Ok && bothMatch;
            end
            configIdle:
                setMatches = fields.isIdleData;
            default:
                ruleExists = 1'b0;  // Detect and unknown codes
        endcase
    end

endmodule

// ==== logic/osTracker.sv ====
`timescale 1ns/10ps

module osTracker (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid,
    input  osPkg::substate_t substate,
    input  logic             ruleExists,
    input  logic             setMatches,
    input  logic             needsStable,
    input  logic             fieldsDiffer,
    output logic             countUp,
    output logic             resetCounter
);
    import osPkg::*;

    trackState_t state;
    trackState_t nextState;
    substate_t   trackedSubstate;
    logic        substateChanged;
    logic        runAccept;

    assign substateChanged = (substate != trackedSubstate);
    assign runAccept       = valid && setMatches && !(needsStable && fieldsDiffer);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state           <= trackIdle;
            trackedSubstate <= '0;
        end
        else
        begin
            state <= nextState;
            if (state == trackIdle && ruleExists)
                trackedSubstate <= substate;
        end
    end

    always_comb
    begin
        nextState    = state;
        countUp      = 1'b0;
        resetCounter = 1'b0;
        case (state)
            trackIdle:
                if (ruleExists)
                    nextState = trackHunt;
            trackHunt:
                if (substateChanged)
                    nextState = trackIdle;
                else if (valid && setMatches)
                begin
                    countUp      = 1'b1;  // First hit clears the counter too
                    resetCounter = 1'b1;
                    nextState    = trackRun;
                end
            trackRun:
                if (substateChanged)
                    nextState = trackIdle;
                else
                begin
                    resetCounter = 1'b1;
                    if (runAccept)
                        countUp = 1'b1;
                    else if (valid)
                        nextState = trackHunt;  // Broken run
                end
            default:
                nextState = trackIdle;
        endcase
    end

endmodule

// ==== logic/osFieldLatch.sv ====
`timescale 1ns/10ps

module osFieldLatch (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid,
    input  osPkg::orderedSet_t orderedSet,
    output logic               fieldsDiffer,
    output osPkg::symbol_t     rateId,
    output osPkg::symbol_t     linkNumberOut,
    output logic               upconfigureCapability
);
    import osPkg::*;

    symbol_t incomingRate;
    logic    incomingUpconfig;

    assign incomingRate     = orderedSet[rateSym*8 +: 8];
    assign incomingUpconfig = orderedSet[upconfigBit];

    // Against the previous valid set
    assign fieldsDiffer = valid &&
        ((incomingRate != rateId) || (incomingUpconfig != upconfigureCapability));

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            rateId                <= '0;
            linkNumberOut         <= '0;
            upconfigureCapability <= 1'b0;
        end
        else if (valid)
        begin
            rateId                <= incomingRate;
            linkNumberOut         <= orderedSet[linkSym*8 +: 8];
            upconfigureCapability <= incomingUpconfig;
        end
    end

endmodule

// ==== logic/osChecker.sv ====
`timescale 1ns/10ps

module osChecker #(
    parameter bit upstreamPort = 1'b0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid,
    input  osPkg::orderedSet_t orderedSet,
    input  osPkg::substate_t   substate,
    input  osPkg::symbol_t     linkNumber,
    input  osPkg::symbol_t     laneNumber,
    output logic               countUp,
    output logic               resetCounter,
    output osPkg::symbol_t     rateId,
    output osPkg::symbol_t     linkNumberOut,
    output logic               upconfigureCapability
);

    logic ruleExists;
    logic setMatches;
    logic needsStable;
    logic fieldsDiffer;

    osFieldsIf fields ();

    osDecoder decoder (
        .orderedSet (orderedSet),
        .linkNumber (linkNumber),
        .laneNumber (laneNumber),
        .fields     (fields.decoder)
    );

    osRuleSelect #(
        .upstreamPort (upstreamPort)
    ) ruleSelect (
        .substate    (substate),
        .fields      (fields.rules),
        .ruleExists  (ruleExists),
        .setMatches  (setMatches),
        .needsStable (needsStable)
    );

    osTracker tracker (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .substate     (substate),
        .ruleExists   (ruleExists),
        .setMatches   (setMatches),
        .needsStable  (needsStable),
        .fieldsDiffer (fieldsDiffer),
        .countUp      (countUp),
        .resetCounter (resetCounter)
    );

    osFieldLatch fieldLatch (
        .clk                   (clk),
        .reset                 (reset),
        .valid                 (valid),
        .orderedSet            (orderedSet),
        .fieldsDiffer          (fieldsDiffer),
        .rateId                (rateId),
        .linkNumberOut         (linkNumberOut),
        .upconfigureCapability (upconfigureCapability)
    );

endmodule

// ==== tb/osChecker_props.sv ====
`timescale 1ns/10ps

module osCheckerProps (
    input logic               clk,
    input logic               reset,
    input logic               valid,
    input osPkg::trackState_t state,
    input logic               countUp,
    input logic               resetCounter
);
    import osPkg::*;

    int failCount = 0;

    countNeedsReset: assert property (@(posedge clk) disable iff (!reset)
        countUp |-> resetCounter)
    else
    begin
        failCount++;
        $error("countUp high while resetCounter low");
    end

    countNeedsValid: assert property (@(posedge clk) disable iff (!reset)
        countUp |-> valid)
    else
    begin
        failCount++;
        $error("countUp high without a valid set");
    end

    // Idle tracker drives nothing
    idleQuiet: assert property (@(posedge clk) disable iff (!reset)
        (state == trackIdle) |-> (!countUp && !resetCounter))
    else
    begin
        failCount++;
        $error("Tracker outputs active in idle state");
    end

endmodule

bind osTracker osCheckerProps props (
    .clk          (clk),
    .reset        (reset),
    .valid        (valid),
    .state        (state),
    .countUp      (countUp),
    .resetCounter (resetCounter)
);

// ==== tb/osCheckerMonitor.sv ====
`timescale 1ns/10ps

module osCheckerMonitor #(
    parameter bit upstreamPort = 1'b0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid,
    input  osPkg::orderedSet_t orderedSet,
    input  osPkg::substate_t   substate,
    input  osPkg::symbol_t     linkNumber,
    input  osPkg::symbol_t     laneNumber,
    input  logic               countUp,
    input  logic               resetCounter,
    input  osPkg::symbol_t     rateId,
    input  osPkg::symbol_t     linkNumberOut,
    input  logic               upconfigureCapability,
    input  int                 testId,
    output int                 errorCount,
    output int                 checkCount
);
    import osPkg::*;

    int        errors = 0;
    int        checks = 0;
    int        testErrors = 0;
    int        testChecks = 0;
    int        lastTestId = 0;
    int        modelState = 0;  // 0 idle, 1 hunt, 2 run
    substate_t heldSubstate = '0;
    symbol_t   storedRate = '0;
    symbol_t   storedLink = '0;
    logic      storedUpconfig = 1'b0;

    assign errorCount = errors;
    assign checkCount = checks;

    function automatic string testName(int id);
        case (id)
            0: return "pollingStates";
            1: return "linkWidth";
            2: return "lanenum";
            3: return "completeAndIdle";
            4: return "mixedStates";
            default: return "wrapUp";
        endcase
    endfunction

    // Returns {rule exists, set matches}
    function automatic logic [1:0] ruleFor(substate_t sub, orderedSet_t os);
        logic ts1;
        logic ts2;
        logic padBoth;
        logic numBoth;
        ts1 = (os[7:0] == symCom || os[7:0] == symGen3Ts1) && os[87:80] == symTs1Id;
        ts2 = (os[7:0] == symCom || os[7:0] == symGen3Ts2) && os[87:80] == symTs2Id;
        padBoth = os[15:8] == symPad && os[23:16] == symPad;
        numBoth = os[15:8] == linkNumber && os[23:16] == laneNumber;
        case (sub)
            pollingActive:
                return {1'b1, (ts1 && padBoth && !(os[43] && !os[42])) || (ts2 && padBoth)};
            pollingConfiguration:
                return {1'b1, ts2 && padBoth};
            configLinkWidthStart:
                return {1'b1, ts1 && os[23:16] == symPad &&
                    (upstreamPort ? os[15:8] != symPad : os[15:8] == linkNumber)};
            configLinkWidthAccept:
                return {upstreamPort,
                    upstreamPort && ts1 && os[15:8] == linkNumber && os[23:16] != symPad};
            configLanenumWait, configLanenumAccept:
                return {1'b1, (upstreamPort ? ts2 : ts1) && numBoth};
            configComplete:
                return {1'b1, ts2 && numBoth};
            configIdle:
                return {1'b1, os[7:0] == symIdle};
            default:
                return 2'b00;
        endcase
    endfunction

    task automatic compare(input string what, input int expected, input int actual);
        checks++;
        testChecks++;
        if (expected != actual)
        begin
            errors++;
            testErrors++;
            $display("** Error: test %s, %s expected 'h%0h actual 'h%0h",
                testName(testId), what, expected, actual);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk)
    begin : model
        logic [1:0] rule;
        logic       expCount;
        logic       expReset;
        logic       differ;
        int         nextState;
        if (testId != lastTestId)
        begin
            $display("Test %s: %s, %0d checks, %0d errors", testName(lastTestId),
                (testErrors == 0) ? "passed" : "failed", testChecks, testErrors);
            testChecks = 0;
            testErrors = 0;
            lastTestId = testId;
        end
        expCount = 1'b0;
        expReset = 1'b0;
        rule = ruleFor(substate, orderedSet);
        differ = orderedSet[39:32] != storedRate || orderedSet[42] != storedUpconfig;
        nextState = modelState;
        if (!reset)
        begin
            nextState = 0;
            storedRate = '0;
            storedLink = '0;
            storedUpconfig = 1'b0;
        end
        else if (modelState == 0)
        begin
            if (rule[1])
            begin
                nextState = 1;
                heldSubstate = substate;
            end
        end
        else if (substate != heldSubstate)
            nextState = 0;
        else if (modelState == 1)
        begin
            if (valid && rule[0])
            begin
                expCount = 1'b1;
                expReset = 1'b1;
                nextState = 2;
            end
        end
        else
        begin
            expReset = 1'b1;
            if (valid && rule[0] && !(substate == configComplete && differ))
                expCount = 1'b1;
            else if (valid)
                nextState = 1;  // Run broken
        end
        compare("countUp", int'(expCount), int'(countUp));
        compare("resetCounter", int'(expReset), int'(resetCounter));
        compare("rateId", int'(storedRate), int'(rateId));
        compare("linkNumberOut", int'(storedLink), int'(linkNumberOut));
        compare("upconfigureCapability", int'(storedUpconfig), int'(upconfigureCapability));
        modelState = nextState;
        if (reset && valid)
        begin
            storedRate = orderedSet[39:32];
            storedLink = orderedSet[15:8];
            storedUpconfig = orderedSet[42];
        end
    end

endmodule

// ==== tb/osCheckerTb.sv ====
`timescale 1ns/10ps

module osCheckerTb #(
    parameter bit upstreamPort = 1'b0
);
    import osPkg::*;

    localparam int clkPeriod  = 8;
    localparam int testCycles = 400;
    localparam int testCount  = 5;

    logic        clk;
    logic        reset;
    logic        valid;
    orderedSet_t orderedSet;
    substate_t   substate;
    symbol_t     linkNumber;
    symbol_t     laneNumber;
    logic        countUp;
    logic        resetCounter;
    symbol_t     rateId;
    symbol_t     linkNumberOut;
    logic        upconfigureCapability;
    int          testId;
    int          errorCount;
    int          checkCount;
    int          seed;
    int          testIndex;
    substate_t   runSubstate;
    symbol_t     runRate;
    logic        runUpconfig;
    logic [31:0] initRandom;

    osChecker #(.upstreamPort(upstreamPort)) UUT (.*);

    osCheckerMonitor #(.upstreamPort(upstreamPort)) monitor (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #(clkPeriod / 2) clk = ~clk;
    end

    // Three times the nominal length of all tests
    initial
    begin
        #(3 * testCount * testCycles * clkPeriod);
        $display("Watchdog timeout, the tests did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Mostly fits the rule for sub, then sometimes one field is broken
    function automatic orderedSet_t buildSet(substate_t sub);
        orderedSet_t os;
        logic [31:0] r;
        logic        ts2;
        int          i;
        for (i = 0; i < 4; i++)
            os[i*32 +: 32] = $random(seed);
        r = $random(seed);
        ts2 = (sub == pollingConfiguration) || (sub == configComplete) ||
            (sub == pollingActive && r[0]) ||
            (upstreamPort && (sub == configLanenumWait || sub == configLanenumAccept));
        os[7:0]   = r[1] ? (ts2 ? symGen3Ts2 : symGen3Ts1) : symCom;
        os[15:8]  = (sub <= pollingConfiguration) ? symPad : linkNumber;
        os[23:16] = (sub <= configLinkWidthStart) ? symPad : laneNumber;
        os[39:32] = runRate;
        os[42]    = runUpconfig;
        os[43]    = 1'b0;
        os[87:80] = ts2 ? symTs2Id : symTs1Id;
        if (sub == configIdle)
            os[7:0] = symIdle;
        if (r[15:8] < 8'd77)  // About 30% corrupted
            case (r[18:16])
                3'd0: os[7:0] = os[7:0] ^ (r[31:24] | 8'h01);
                3'd1: os[87:80] = r[31:24];
                3'd2: os[15:8] = r[31:24];
                3'd3: os[23:16] = r[31:24];
                3'd4, 3'd5: os[39:32] = r[31:24];
                3'd6: os[42] = !os[42];
                default: os[43] = 1'b1;
            endcase
        return os;
    endfunction

    task automatic runTest(input int id);
        int          cycle;
        int          runLeft;
        int          first;
        int          span;
        logic [31:0] r;
        runLeft = 0;
        first = (id < 4) ? 2 + 2 * id : 2;  // Substate range of this test
        span  = (id < 4) ? 2 : 8;
        testId <= id;
        for (cycle = 0; cycle < testCycles; cycle++)
        begin
            @(posedge clk);
            if (runLeft == 0)
            begin
                r = $random(seed);
                runLeft = 20 + int'(r % 41);
                if ((r >> 8) % 5 == 0)
                    runSubstate = r[7] ? detectActive : detectQuiet;
                else
                    runSubstate = substate_t'(first + int'((r >> 12) % span));
                r = $random(seed);
                runRate = r[7:0];
                runUpconfig = r[8];
                substate <= runSubstate;
            end
            r = $random(seed);
            valid <= (r % 10) < 7;
            orderedSet <= buildSet(runSubstate);
            runLeft--;
        end
    endtask

    initial
    begin
        seed = 50314;
        reset = 1'b0;
        valid = 1'b0;
        orderedSet = '0;
        substate = detectQuiet;
        runSubstate = detectQuiet;
        runRate = '0;
        runUpconfig = 1'b0;
        testId = 0;
        initRandom = $random(seed);
        linkNumber = {1'b0, initRandom[6:0]};  // Never the pad symbol
        laneNumber = {1'b0, initRandom[14:8]};
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        for (testIndex = 0; testIndex < testCount; testIndex++)
            runTest(testIndex);
        @(posedge clk);
        valid <= 1'b0;
        testId <= testCount;
        repeat (2) @(posedge clk);
        $display("Totals: %0d checks, %0d errors, %0d assertion failures",
            checkCount, errorCount, UUT.tracker.props.failCount);
        if (errorCount == 0 && checkCount > 0 && UUT.tracker.props.failCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/osPkg.sv
logic/osFieldsIf.sv
logic/osDecoder.sv
logic/osRuleSelect.sv
logic/osTracker.sv
logic/osFieldLatch.sv
logic/osChecker.sv
tb/osChecker_props.sv
tb/osCheckerMonitor.sv
tb/osCheckerTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = osCheckerTb
FILELIST = filelist.f
RUNFLAGS = +verilator+error+limit+1000
PASSMSG  = Simulation finished: PASS

.PHONY: simulate clean

simulate:
	@for port in 0 1; do \
		$(TOOL) $(FLAGS) -GupstreamPort=$$port --top-module $(TOP) \
			-f $(FILELIST) -Mdir build_$$port || exit 1; \
		out=$$(./build_$$port/V$(TOP) $(RUNFLAGS)); \
		echo "$$out"; \
		echo "$$out" | grep -q "$(PASSMSG)" || exit 1; \
	done

clean:
	rm -rf build_0 build_1
